// ==== build.f ====
verilog/dcachePkg.sv
verilog/cacheStorage.sv
verilog/victimSelect.sv
verilog/dcacheControl.sv
verilog/dcache.sv
tests/memoryModel.sv
tests/dcacheTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module dcacheTb -o dcacheSim
./obj_dir/dcacheSim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi

// ==== tests/dcacheTb.sv ====
// Data cache testbench running a stimulus table against a shadow word map
`timescale 1ns/1ps

module dcacheTb
	import dcachePkg::*;
;

	localparam int        HALF_PERIOD  = 2;
	localparam int        RESET_CYCLES = 5;
	localparam int        ENTRY_COUNT  = 20;
	localparam word_t     MEM_PATTERN  = 32'hA5A5_0000;
	localparam word_t     LFSR_SEED    = 32'd67145;
	localparam word_t     LFSR_TAPS    = 32'h8020_0003;
	localparam logic [1:0] OP_READ     = 2'd0;
	localparam logic [1:0] OP_WRITE    = 2'd1;
	localparam logic [1:0] OP_HALT     = 2'd2;

	// Operation, address, store data and what the memory port should see
	typedef struct packed {
		logic [1:0] op;
		word_t      addr;
		word_t      data;
		logic [2:0] expReads;
		logic [2:0] expWrites;
		word_t      wbBase;
		logic [1:0] latency;
	} tableEntry;

	logic   CLK;
	logic   nRST;
	cpuReq  req;
	cpuResp resp;
	memReq  mem;
	memResp memIn;
	word_t  peekAddr;
	word_t  peekData;

	tableEntry stimTable [ENTRY_COUNT];
	int        entryCount;
	int        currentEntry;
	int        checkCount;
	int        errorCount;
	int        enableCycles;
	word_t     lfsrState;
	word_t     shadow [word_t];
	word_t     writtenAddrs [$];
	logic      xferIsWrite [$];
	word_t     xferAddr [$];
	word_t     xferData [$];

	dcache dcache_i (
		.CLK   (CLK),
		.nRST  (nRST),
		.req   (req),
		.resp  (resp),
		.mem   (mem),
		.memIn (memIn)
	);

	memoryModel memory_i (
		.CLK      (CLK),
		.nRST     (nRST),
		.req      (mem),
		.resp     (memIn),
		.peekAddr (peekAddr),
		.peekData (peekData)
	);

	initial CLK = 1'b0;
	always #(HALF_PERIOD) CLK = ~CLK;

	function automatic word_t lfsrStep(input word_t s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic drawRandomWord(output word_t w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w = {w[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	function automatic word_t expectedWord(input word_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a ^ MEM_PATTERN;
	endfunction

	task automatic checkValue(input string what, input word_t actual, input word_t expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0d ns: entry %0d %s is %h, expected %h",
				$time, currentEntry, what, actual, expected);
		end
	endtask

	task automatic addEntry(input logic [1:0] op, input word_t addr, input int reads,
		input int writes, input word_t wbBase, input int latency);
		word_t data;
		data = '0;
		if (op == OP_WRITE) begin
			drawRandomWord(data);
		end
		stimTable[entryCount] = '{op: op, addr: addr, data: data, expReads: 3'(reads),
			expWrites: 3'(writes), wbBase: wbBase, latency: 2'(latency)};
		entryCount++;
	endtask

	// Set 0 gets three tags, sets 1 and 2 see dirty evictions, set 7 stays dirty
	task automatic buildTable();
		addEntry(OP_READ,  32'h040, 2, 0, 32'h0, 0);
		addEntry(OP_READ,  32'h044, 0, 0, 32'h0, 1);
		addEntry(OP_WRITE, 32'h048, 2, 0, 32'h0, 0);
		addEntry(OP_WRITE, 32'h04C, 0, 0, 32'h0, 2);
		addEntry(OP_READ,  32'h048, 0, 0, 32'h0, 1);
		addEntry(OP_READ,  32'h04C, 0, 0, 32'h0, 1);
		addEntry(OP_READ,  32'h080, 2, 0, 32'h0, 0);
		addEntry(OP_READ,  32'h0C0, 2, 0, 32'h0, 0);
		addEntry(OP_READ,  32'h080, 0, 0, 32'h0, 1);
		addEntry(OP_READ,  32'h040, 2, 0, 32'h0, 0);
		addEntry(OP_READ,  32'h088, 2, 0, 32'h0, 0);
		addEntry(OP_READ,  32'h0CC, 2, 2, 32'h048, 0);
		addEntry(OP_READ,  32'h048, 2, 0, 32'h0, 0);
		addEntry(OP_WRITE, 32'h050, 2, 0, 32'h0, 0);
		addEntry(OP_WRITE, 32'h094, 2, 0, 32'h0, 0);
		addEntry(OP_WRITE, 32'h0D0, 2, 2, 32'h050, 0);
		addEntry(OP_READ,  32'h050, 2, 2, 32'h090, 0);
		addEntry(OP_WRITE, 32'h03C, 2, 0, 32'h0, 0);
		addEntry(OP_WRITE, 32'h1F8, 2, 0, 32'h0, 0);
		addEntry(OP_HALT,  32'h000, 0, 6, 32'h0, 0);
	endtask

	// Logs every word that crosses the memory port
	task automatic sampleMemory();
		if (mem.ren || mem.wen) begin
			enableCycles++;
			if (!memIn.dwait) begin
				xferIsWrite.push_back(mem.wen);
				xferAddr.push_back(mem.addr);
				xferData.push_back(mem.wen ? mem.storeData : memIn.dload);
			end
		end
	endtask

	task automatic runEntry(input tableEntry e);
		int    cycles;
		int    writes;
		int    reads;
		logic  done;
		word_t fillBase;
		xferIsWrite.delete();
		xferAddr.delete();
		xferData.delete();
		enableCycles = 0;
		cycles = 0;
		writes = 0;
		reads = 0;
		done = 1'b0;
		fillBase = {e.addr[31:3], 3'b000};
		@(posedge CLK);
		req.ren       <= (e.op == OP_READ);
		req.wen       <= (e.op == OP_WRITE);
		req.halt      <= (e.op == OP_HALT);
		req.addr.raw  <= e.addr;
		req.storeData <= e.data;
		while (!done) begin
			@(negedge CLK);
			cycles++;
			sampleMemory();
			done = (e.op == OP_HALT) ? resp.flushed : resp.hit;
		end
		// Victim words go out before any fill word comes in
		for (int i = 0; i < xferAddr.size(); i++) begin
			if (xferIsWrite[i]) begin
				checkValue("write-back data", xferData[i], expectedWord(xferAddr[i]));
				if (e.op != OP_HALT) begin
					checkValue("write-back address", xferAddr[i], e.wbBase + 32'(4 * writes));
				end
				writes++;
			end else begin
				checkValue("writes before fill", 32'(writes), 32'(e.expWrites));
				checkValue("fill address", xferAddr[i], fillBase + 32'(4 * reads));
				checkValue("fill data", xferData[i], expectedWord(xferAddr[i]));
				reads++;
			end
		end
		checkValue("write-back words", 32'(writes), 32'(e.expWrites));
		checkValue("fill words", 32'(reads), 32'(e.expReads));
		if ((e.expReads == 0) && (e.expWrites == 0)) begin
			checkValue("memory enable cycles", 32'(enableCycles), 32'd0);
		end
		if (e.latency != 0) begin
			checkValue("hit latency", 32'(cycles - 1), 32'(e.latency));
		end
		if (e.op == OP_READ) begin
			checkValue("load data", resp.loadData, expectedWord(e.addr));
		end
		if (e.op == OP_WRITE) begin
			if (!shadow.exists(e.addr)) begin
				writtenAddrs.push_back(e.addr);
			end
			shadow[e.addr] = e.data;
		end
	endtask

	task automatic checkFlushHold();
		repeat (8) begin
			@(negedge CLK);
			checkValue("flushed held", 32'(resp.flushed), 32'd1);
			checkValue("memory enable after flush", 32'(mem.ren || mem.wen), 32'd0);
		end
	endtask

	task automatic checkMemoryImage();
		foreach (writtenAddrs[i]) begin
			@(posedge CLK);
			peekAddr <= writtenAddrs[i];
			@(posedge CLK);
			@(negedge CLK);
			checkValue("memory word", peekData, expectedWord(writtenAddrs[i]));
		end
	endtask

	// Watchdog
	initial begin
		#(2 * HALF_PERIOD * (ENTRY_COUNT * 40 + RESET_CYCLES));
		$display("Timeout: the cache did not answer within %0d cycles", ENTRY_COUNT * 40);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		nRST = 1'b0;
		req = '0;
		peekAddr = '0;
		entryCount = 0;
		currentEntry = 0;
		checkCount = 0;
		errorCount = 0;
		lfsrState = LFSR_SEED;
		buildTable();
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		checkValue("hit after reset", 32'(resp.hit), 32'd0);
		checkValue("flushed after reset", 32'(resp.flushed), 32'd0);
		checkValue("memory read after reset", 32'(mem.ren), 32'd0);
		checkValue("memory write after reset", 32'(mem.wen), 32'd0);
		for (int i = 0; i < ENTRY_COUNT; i++) begin
			currentEntry = i + 1;
			runEntry(stimTable[i]);
		end
		checkFlushHold();
		checkMemoryImage();
		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== tests/memoryModel.sv ====
// Behavioral word memory answering the cache memory port after a fixed wait
`timescale 1ns/1ps

module memoryModel
	import dcachePkg::*;
(
	input  logic   CLK,
	input  logic   nRST,
	input  memReq  req,
	output memResp resp,
	input  word_t  peekAddr,
	output word_t  peekData
);

	localparam int    WAIT_CYCLES  = 3;
	localparam int    DEPTH_W      = 10;
	localparam word_t FILL_PATTERN = 32'hA5A5_0000;

	word_t               words [2**DEPTH_W];
	logic [2**DEPTH_W-1:0] writtenMask;
	logic [1:0]          waitCount;
	logic                active;
	logic                transfer;
	word_t               loadWord;

	assign active   = req.ren || req.wen;
	assign transfer = active && (waitCount == 2'(WAIT_CYCLES));
	assign resp     = '{dwait: !transfer, dload: loadWord};

	// Words never written still follow the address rule
	function automatic word_t readWord(input word_t a);
		if (writtenMask[a[DEPTH_W+1:2]]) begin
			return words[a[DEPTH_W+1:2]];
		end
		return a ^ FILL_PATTERN;
	endfunction

	always_ff @(posedge CLK) begin
		if (transfer && req.wen) begin
			words[req.addr[DEPTH_W+1:2]] <= req.storeData;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			waitCount   <= '0;
			writtenMask <= '0;
			loadWord    <= '0;
			peekData    <= '0;
		end else begin
			peekData <= readWord(peekAddr);
			if (!active || transfer) begin
				waitCount <= '0;
			end else begin
				waitCount <= waitCount + 2'd1;
			end
			// Read data is ready for the cycle where wait drops
			if (active && (waitCount == 2'(WAIT_CYCLES - 1))) begin
				loadWord <= readWord(req.addr);
			end
			if (transfer && req.wen) begin
				writtenMask[req.addr[DEPTH_W+1:2]] <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/cacheStorage.sv ====
// Frame storage for both ways with tag compare, load word select and frame updates
`timescale 1ns/1ps

module cacheStorage
	import dcachePkg::*;
(
	input  logic                CLK,
	input  logic                nRST,
	input  dcacheAddrU          addr,
	input  word_t               storeData,
	input  word_t               fillData,
	input  storeCmd             cmd,
	input  logic                targetWay,
	input  logic [IDX_W-1:0]    targetIdx,
	output lookupRes            lookup,
	output logic [FRAMES-1:0]   validMap,
	output logic [FRAMES-1:0]   dirtyMap,
	output cacheFrame           victimFrame
);

	// Tags and blocks of both ways
	logic [TAG_W-1:0] tagMem [WAYS][SETS];
	cacheBlock        dataMem [WAYS][SETS];
	logic [FRAMES-1:0] validBits;
	logic [FRAMES-1:0] dirtyBits;

	logic [WAYS-1:0]   wayHit;
	logic [IDX_W-1:0]  reqIdx;
	logic [FRAME_W-1:0] targetFrame;
	cacheBlock         hitBlock;

	assign reqIdx      = addr.f.idx;
	assign targetFrame = {targetWay, targetIdx};

	// Tag compare against both ways of the requested set
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			wayHit[w] = validBits[w * SETS + int'(reqIdx)] &&
				(tagMem[w][reqIdx] == addr.f.tag);
		end
	end

	assign hitBlock = dataMem[wayHit[1]][reqIdx];

	always_comb begin
		lookup.hit    = |wayHit;
		lookup.hitWay = wayHit[1];
		if (addr.f.blkoff) begin
			lookup.loadWord = hitBlock.wordB;
		end else begin
			lookup.loadWord = hitBlock.wordA;
		end
	end

	// Frame picked by victim selection, used for write-back
	always_comb begin
		victimFrame.tag   = tagMem[targetWay][targetIdx];
		victimFrame.idx   = targetIdx;
		victimFrame.data  = dataMem[targetWay][targetIdx];
		victimFrame.valid = validBits[targetFrame];
		victimFrame.dirty = dirtyBits[targetFrame];
	end

	assign validMap = validBits;
	assign dirtyMap = dirtyBits;

	// Payload updates
	always_ff @(posedge CLK) begin
		if (cmd.fill) begin
			if (!cmd.fillWord) begin
				dataMem[targetWay][targetIdx].wordA <= fillData;
			end else begin
				dataMem[targetWay][targetIdx].wordB <= fillData;
				// Tag lands with the second word
				tagMem[targetWay][targetIdx] <= addr.f.tag;
			end
		end
		if (cmd.write) begin
			if (addr.f.blkoff) begin
				dataMem[targetWay][targetIdx].wordB <= storeData;
			end else begin
				dataMem[targetWay][targetIdx].wordA <= storeData;
			end
		end
	end

	// Valid and dirty flags
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else begin
			if (cmd.fill && cmd.fillWord) begin
				validBits[targetFrame] <= 1'b1;
				dirtyBits[targetFrame] <= 1'b0;
			end
			if (cmd.write) begin
				dirtyBits[targetFrame] <= 1'b1;
			end
			if (cmd.clean) begin
				// Second word of a write-back is in memory
				dirtyBits[targetFrame] <= 1'b0;
			end
		end
	end

	// One block never lives in both ways
	assert property (@(posedge CLK) disable iff (!nRST) !(wayHit[0] && wayHit[1]))
		else $error("request hits in both ways of set %0d", reqIdx);

endmodule

// ==== verilog/dcache.sv ====
// Two-way write-back data cache top connecting storage, victim choice and FSM
`timescale 1ns/1ps

module dcache
	import dcachePkg::*;
(
	input  logic   CLK,
	input  logic   nRST,
	input  cpuReq  req,
	output cpuResp resp,
	output memReq  mem,
	input  memResp memIn
);

	storeCmd           cmd;
	logic              touch;
	lookupRes          lookup;
	logic [FRAMES-1:0] validMap;
	logic [FRAMES-1:0] dirtyMap;
	cacheFrame         victimFrame;
	logic              targetWay;
	logic [IDX_W-1:0]  targetIdx;
	logic              anyDirty;

	cacheStorage storage_i (
		.CLK         (CLK),
		.nRST        (nRST),
		.addr        (req.addr),
		.storeData   (req.storeData),
		.fillData    (memIn.dload),
		.cmd         (cmd),
		.targetWay   (targetWay),
		.targetIdx   (targetIdx),
		.lookup      (lookup),
		.validMap    (validMap),
		.dirtyMap    (dirtyMap),
		.victimFrame (victimFrame)
	);

	victimSelect victim_i (
		.CLK       (CLK),
		.nRST      (nRST),
		.addr      (req.addr),
		.halt      (req.halt),
		.lookup    (lookup),
		.touch     (touch),
		.validMap  (validMap),
		.dirtyMap  (dirtyMap),
		.targetWay (targetWay),
		.targetIdx (targetIdx),
		.anyDirty  (anyDirty)
	);

	dcacheControl control_i (
		.CLK         (CLK),
		.nRST        (nRST),
		.req         (req),
		.memIn       (memIn),
		.lookup      (lookup),
		.victimFrame (victimFrame),
		.anyDirty    (anyDirty),
		.cmd         (cmd),
		.touch       (touch),
		.resp        (resp),
		.mem         (mem)
	);

endmodule

// ==== verilog/dcacheControl.sv ====
// Cache controller FSM sequencing hits, write-backs, fills and flush
`timescale 1ns/1ps

module dcacheControl
	import dcachePkg::*;
(
	input  logic      CLK,
	input  logic      nRST,
	input  cpuReq     req,
	input  memResp    memIn,
	input  lookupRes  lookup,
	input  cacheFrame victimFrame,
	input  logic      anyDirty,
	output storeCmd   cmd,
	output logic      touch,
	output cpuResp    resp,
	output memReq     mem
);

	ctrlState   state;
	ctrlState   nextState;
	dcacheAddrU wbAddr;
	dcacheAddrU fillAddr;
	logic       memDone;

	assign memDone = !memIn.dwait;

	// Write-back goes to the victim's own block
	always_comb begin
		wbAddr.f.tag    = victimFrame.tag;
		wbAddr.f.idx    = victimFrame.idx;
		wbAddr.f.blkoff = 1'b0;
		wbAddr.f.bytoff = 2'b00;
	end

	// Fill starts at the block-aligned request address
	always_comb begin
		fillAddr        = req.addr;
		fillAddr.f.blkoff = 1'b0;
		fillAddr.f.bytoff = 2'b00;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (req.halt) begin
					nextState = FLUSH;
				end else if (req.ren && lookup.hit) begin
					nextState = READHIT;
				end else if (req.wen && lookup.hit) begin
					nextState = OVERWRITE;
				end else if (req.ren || req.wen) begin
					// On a miss the dirty victim goes out first
					if (victimFrame.valid && victimFrame.dirty) begin
						nextState = CLEANA;
					end else begin
						nextState = FILLA;
					end
				end
			end
			READHIT:   nextState = IDLE;
			OVERWRITE: nextState = WRITEHIT;
			WRITEHIT:  nextState = IDLE;
			CLEANA: begin
				if (memDone) begin
					nextState = CLEANB;
				end
			end
			CLEANB: begin
				if (memDone) begin
					nextState = req.halt ? FLUSH : FILLA;
				end
			end
			FILLA: begin
				if (memDone) begin
					nextState = FILLB;
				end
			end
			FILLB: begin
				if (memDone) begin
					nextState = req.wen ? OVERWRITE : IDLE;
				end
			end
			FLUSH:   nextState = anyDirty ? CLEANA : STOP;
			STOP:    nextState = STOP;
			default: nextState = IDLE;
		endcase
	end

	// Fill and clean orders land only when the memory word transfers
	always_comb begin
		cmd.fill     = ((state == FILLA) || (state == FILLB)) && memDone;
		cmd.fillWord = (state == FILLB);
		cmd.write    = (state == OVERWRITE);
		cmd.clean    = (state == CLEANB) && memDone;
		cmd.touch    = (state == READHIT) || (state == WRITEHIT);
	end

	assign touch = cmd.touch;

	always_comb begin
		resp.hit      = (state == READHIT) || (state == WRITEHIT);
		resp.loadData = (state == READHIT) ? lookup.loadWord : '0;
		resp.flushed  = (state == STOP);
	end

	always_comb begin
		mem = '0;
		case (state)
			CLEANA: begin
				mem.wen       = 1'b1;
				mem.addr      = wbAddr.raw;
				mem.storeData = victimFrame.data.wordA;
			end
			CLEANB: begin
				mem.wen       = 1'b1;
				mem.addr      = wbAddr.raw + WORD_BYTES;
				mem.storeData = victimFrame.data.wordB;
			end
			FILLA: begin
				mem.ren  = 1'b1;
				mem.addr = fillAddr.raw;
			end
			FILLB: begin
				mem.ren  = 1'b1;
				mem.addr = fillAddr.raw + WORD_BYTES;
			end
			default: begin
			end
		endcase
	end

	assert property (@(posedge CLK) disable iff (!nRST) !(mem.ren && mem.wen))
		else $error("memory read and write requested together");

	// Once flushed, the cache stays stopped until reset
	assert property (@(posedge CLK) disable iff (!nRST) resp.flushed |=> resp.flushed)
		else $error("flushed dropped before reset");

endmodule

// ==== verilog/dcachePkg.sv ====
// Data cache package with geometry, address layout, frame and port types
package dcachePkg;

	// Geometry
	localparam int WORD_W     = 32;
	localparam int SETS       = 8;
	localparam int IDX_W      = 3;
	localparam int TAG_W      = 26;
	localparam int WAYS       = 2;
	localparam int WORD_BYTES = 4;
	localparam int FRAMES     = WAYS * SETS;
	localparam int FRAME_W    = 4;

	typedef logic [WORD_W-1:0] word_t;

	// Request word seen either as raw address or as its fields
	typedef union packed {
		word_t raw;
		struct packed {
			logic [TAG_W-1:0] tag;
			logic [IDX_W-1:0] idx;
			logic             blkoff;
			logic [1:0]       bytoff;
		} f;
	} dcacheAddrU;

	typedef struct packed {
		word_t wordA;
		word_t wordB;
	} cacheBlock;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		cacheBlock        data;
		logic             valid;
		logic             dirty;
	} cacheFrame;

	// Datapath side
	typedef struct packed {
		logic       ren;
		logic       wen;
		dcacheAddrU addr;
		word_t      storeData;
		logic       halt;
	} cpuReq;

	typedef struct packed {
		logic  hit;
		word_t loadData;
		logic  flushed;
	} cpuResp;

	// Memory side
	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t storeData;
	} memReq;

	typedef struct packed {
		logic  dwait;
		word_t dload;
	} memResp;

	// Orders from the FSM to the frame storage
	typedef struct packed {
		logic fill;
		logic fillWord;
		logic write;
		logic clean;
		logic touch;
	} storeCmd;

	typedef struct packed {
		logic  hit;
		logic  hitWay;
		word_t loadWord;
	} lookupRes;

	typedef enum logic [3:0] {
		IDLE      = 4'h0,
		READHIT   = 4'h1,
		OVERWRITE = 4'h2,
		WRITEHIT  = 4'h3,
		CLEANA    = 4'h4,
		CLEANB    = 4'h5,
		FILLA     = 4'h6,
		FILLB     = 4'h7,
		FLUSH     = 4'h8,
		STOP      = 4'h9
	} ctrlState;

endpackage

// ==== verilog/victimSelect.sv ====
// LRU tracking and target frame choice for fills, write-backs and flush
`timescale 1ns/1ps

module victimSelect
	import dcachePkg::*;
(
	input  logic              CLK,
	input  logic              nRST,
	input  dcacheAddrU        addr,
	input  logic              halt,
	input  lookupRes          lookup,
	input  logic              touch,
	input  logic [FRAMES-1:0] validMap,
	input  logic [FRAMES-1:0] dirtyMap,
	output logic              targetWay,
	output logic [IDX_W-1:0]  targetIdx,
	output logic              anyDirty
);

	// Way most recently used, one bit per set
	logic [SETS-1:0]    mru;
	logic [FRAME_W-1:0] flushFrame;
	logic [IDX_W-1:0]   reqIdx;

	assign reqIdx   = addr.f.idx;
	assign anyDirty = |dirtyMap;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mru <= '0;
		end else if (touch) begin
			mru[reqIdx] <= lookup.hitWay;
		end
	end

	// Lowest dirty frame wins, which is way 0 sets 0..7 then way 1
	always_comb begin
		flushFrame = '0;
		for (int i = FRAMES - 1; i >= 0; i--) begin
			if (dirtyMap[i]) begin
				flushFrame = FRAME_W'(i);
			end
		end
	end

	always_comb begin
		if (halt) begin
			targetWay = flushFrame[FRAME_W-1];
			targetIdx = flushFrame[IDX_W-1:0];
		end else begin
			targetIdx = reqIdx;
			if (lookup.hit) begin
				targetWay = lookup.hitWay;
			end else if (!validMap[int'(reqIdx)]) begin
				targetWay = 1'b0;
			end else if (!validMap[SETS + int'(reqIdx)]) begin
				targetWay = 1'b1;
			end else begin
				targetWay = ~mru[reqIdx];
			end
		end
	end

	// Flush always works on a valid frame that really holds dirty data
	assert property (@(posedge CLK) disable iff (!nRST)
		(halt && anyDirty) |-> (validMap[{targetWay, targetIdx}] &&
			dirtyMap[{targetWay, targetIdx}]))
		else $error("flush target way %0d set %0d is not valid and dirty",
			targetWay, targetIdx);

endmodule
